// File: hdl/exec_pkg.sv
// Widths, micro-op encodings and unit selects shared by the execute stage
// Micro-op codes only mean something together with the unit one-hot
`default_nettype none

package exec_pkg;

    localparam int XLEN  = 32;          // Data word width
    localparam int REG_W = 5;           // Register address width

    typedef logic [XLEN-1:0] xword_t;

    // Micro-op, read plain or as a branch class above an operation
    typedef union packed {
        logic [4:0] code;
        struct packed {
            logic [1:0] cls;            // 00 conditional, 10 unconditional
            logic [2:0] op;
        } br;
    } uop_t;

    typedef logic [3:0] fu_t;           // One-hot unit select

    // ------------------------------
    // ALU micro-ops
    localparam logic [4:0] ALU_ADD  = 5'b00001;
    localparam logic [4:0] ALU_SUB  = 5'b00010;
    localparam logic [4:0] ALU_XOR  = 5'b00011;
    localparam logic [4:0] ALU_OR   = 5'b00100;
    localparam logic [4:0] ALU_AND  = 5'b00101;
    localparam logic [4:0] ALU_SLL  = 5'b00110;
    localparam logic [4:0] ALU_SRL  = 5'b00111;
    localparam logic [4:0] ALU_SRA  = 5'b01000;
    localparam logic [4:0] ALU_SLT  = 5'b01001;
    localparam logic [4:0] ALU_SLTU = 5'b01010;

    // ------------------------------
    // Branch unit micro-ops
    localparam logic [4:0] CFU_BEQ       = 5'b00001;
    localparam logic [4:0] CFU_BNE       = 5'b00010;
    localparam logic [4:0] CFU_BLT       = 5'b00011;
    localparam logic [4:0] CFU_BGE       = 5'b00100;
    localparam logic [4:0] CFU_BLTU      = 5'b00101;
    localparam logic [4:0] CFU_BGEU      = 5'b00110;
    localparam logic [4:0] CFU_TAKEN     = 5'b01001;  // Outcome, stage 3 only
    localparam logic [4:0] CFU_NOT_TAKEN = 5'b01010;  // Outcome, stage 3 only
    localparam logic [4:0] CFU_JALI      = 5'b10001;
    localparam logic [4:0] CFU_JALR      = 5'b10010;

    // Multiply and load/store
    localparam logic [4:0] MUL_MUL   = 5'b00000;
    localparam logic [4:0] MUL_MULHU = 5'b00001;
    localparam int         LSU_LOAD_BIT = 3;          // Set for loads

    // Unit one-hot bit positions
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;

    // ------------------------------
    // Multiplier sequencing
    localparam int MUL_STEPS = 32;      // One step per multiplier bit
    localparam int MUL_CNT_W = 6;       // Must hold MUL_STEPS
    localparam logic [1:0] MUL_ST_IDLE = 2'd0;
    localparam logic [1:0] MUL_ST_RUN  = 2'd1;
    localparam logic [1:0] MUL_ST_DONE = 2'd2;

endpackage

`default_nettype wire

// File: hdl/exec_alu.sv
// Single-cycle ALU, result is zero unless an ALU op is presented
// Sum and compare flags are always live for the other units
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
    input  logic             i_fu_alu,          // ALU op presented
    input  logic             i_fu_cfu,          // Branch op presented
    input  exec_pkg::uop_t   i_uop,             // Micro-op
    input  exec_pkg::xword_t i_lhs,             // Operand A
    input  exec_pkg::xword_t i_rhs,             // Operand B
    output exec_pkg::xword_t o_result,          // ALU result
    output exec_pkg::xword_t o_sum,             // lhs + rhs
    output logic             o_lt,              // lhs < rhs
    output logic             o_eq               // lhs == rhs
);
    import exec_pkg::*;

    logic          cmp_unsigned;                // sltu, bltu, bgeu
    logic [XLEN:0] diff;                        // Borrow in top bit
    logic [4:0]    shamt;

    assign cmp_unsigned = (i_fu_alu && i_uop.code == ALU_SLTU) ||
                          (i_fu_cfu && (i_uop.code == CFU_BLTU ||
                                        i_uop.code == CFU_BGEU));

    assign o_sum = i_lhs + i_rhs;               // Also addresses and jalr
    assign diff  = {1'b0, i_lhs} - {1'b0, i_rhs};
    assign shamt = i_rhs[4:0];
    assign o_eq  = (i_lhs == i_rhs);

    // Borrow is the unsigned answer, differing signs flip it for signed
    assign o_lt = cmp_unsigned ? diff[XLEN] :
                  (diff[XLEN] ^ i_lhs[XLEN-1] ^ i_rhs[XLEN-1]);

    // ------------------------------
    // Operation select
    always_comb begin
        o_result = '0;
        if (i_fu_alu) begin
            case (i_uop.code)
                ALU_ADD:  o_result = o_sum;
                ALU_SUB:  o_result = diff[XLEN-1:0];
                ALU_XOR:  o_result = i_lhs ^ i_rhs;
                ALU_OR:   o_result = i_lhs | i_rhs;
                ALU_AND:  o_result = i_lhs & i_rhs;
                ALU_SLL:  o_result = i_lhs << shamt;
                ALU_SRL:  o_result = i_lhs >> shamt;
                ALU_SRA:  o_result = xword_t'($signed(i_lhs) >>> shamt);
                ALU_SLT,
                ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt};
                default:  o_result = '0;        // Unknown code
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_result_sel.sv
// Builds the stage-3 operands and micro-op from the unit results
// Unit select is expected one-hot, or zero while nothing is presented
`timescale 1ns/100ps
`default_nettype none

module exec_result_sel (
    input  exec_pkg::fu_t         i_fu,              // Unit one-hot
    input  exec_pkg::uop_t        i_uop,             // Stage-2 micro-op
    input  exec_pkg::xword_t      i_opr_c,           // Branch target or store data
    input  exec_pkg::xword_t      i_alu_result,
    input  exec_pkg::xword_t      i_alu_sum,
    input  logic                  i_lt,
    input  logic                  i_eq,
    input  logic [2*exec_pkg::XLEN-1:0] i_product,   // Full unsigned product
    output exec_pkg::xword_t      o_opr_a,
    output exec_pkg::xword_t      o_opr_b,
    output exec_pkg::uop_t        o_uop,
    output exec_pkg::xword_t      o_fwd_wdata,
    output logic                  o_fwd_load
);
    import exec_pkg::*;

    logic   cfu_cond;                           // Conditional branch
    logic   taken;
    xword_t cfu_base;                           // Target before bit 0 clear
    xword_t mul_fwd;

    // ------------------------------
    // Branches and jumps
    assign cfu_cond = i_fu[P_FU_CFU] && i_uop.br.cls == 2'b00;

    always_comb begin
        case (i_uop.br.op)
            CFU_BEQ[2:0]:  taken = i_eq;
            CFU_BNE[2:0]:  taken = !i_eq;
            CFU_BLT[2:0]:  taken = i_lt;
            CFU_BGE[2:0]:  taken = !i_lt;
            CFU_BLTU[2:0]: taken = i_lt;        // ALU compared unsigned
            CFU_BGEU[2:0]: taken = !i_lt;
            default:       taken = 1'b0;
        endcase
    end

    // Register plus offset for jalr, decode precomputes jal and branch targets
    assign cfu_base = (i_uop.code == CFU_JALR) ? i_alu_sum : i_opr_c;

    assign o_uop.code = cfu_cond ? (taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop.code;

    // ------------------------------
    // Operand select
    assign o_opr_a = ({XLEN{i_fu[P_FU_ALU]}} & i_alu_result)
                   | ({XLEN{i_fu[P_FU_MUL]}} & i_product[XLEN-1:0])
                   | ({XLEN{i_fu[P_FU_LSU]}} & i_alu_sum)
                   | ({XLEN{i_fu[P_FU_CFU]}} & {cfu_base[XLEN-1:1], 1'b0});

    assign o_opr_b = ({XLEN{i_fu[P_FU_MUL]}} & i_product[2*XLEN-1:XLEN])
                   | ({XLEN{i_fu[P_FU_LSU]}} & i_opr_c);

    // Forwarded word that a register write would see
    assign mul_fwd = (i_uop.code == MUL_MULHU) ? i_product[2*XLEN-1:XLEN] :
                     (i_uop.code == MUL_MUL)   ? i_product[XLEN-1:0] : '0;
    assign o_fwd_wdata = i_alu_result | ({XLEN{i_fu[P_FU_MUL]}} & mul_fwd);
    assign o_fwd_load  = i_fu[P_FU_LSU] && i_uop.code[LSU_LOAD_BIT];

    always_comb begin
        if (!$isunknown(i_fu)) begin
            assert ($onehot0(i_fu)) else $error("Unit select not one-hot: %b", i_fu);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mul_ctrl_fsm.sv
// Multiply sequencer runs IDLE then RUN for MUL_STEPS cycles then DONE
// DONE holds until the stage accepts the instruction
// A flush always wins and returns it to IDLE
`timescale 1ns/100ps
`default_nettype none

module mul_ctrl_fsm (
    input  logic g_clk,
    input  logic g_resetn,
    input  logic i_start,               // Valid multiply presented
    input  logic i_accept,              // Stage accepts this cycle
    input  logic i_flush,
    input  logic i_last,                // Final step under way
    output logic o_load,                // Capture operands, clear count
    output logic o_step,                // One shift-add step
    output logic o_ready                // Product complete
);
    import exec_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nx;

    always_comb begin
        state_nx = state;
        case (state)
            MUL_ST_IDLE: if (i_start) state_nx = MUL_ST_RUN;
            MUL_ST_RUN:  if (i_last) state_nx = MUL_ST_DONE;
            MUL_ST_DONE: if (i_accept) state_nx = MUL_ST_IDLE;
            default:     state_nx = MUL_ST_IDLE;
        endcase
        if (i_flush) begin
            state_nx = MUL_ST_IDLE;     // Abort whatever is running
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= MUL_ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    assign o_load  = state == MUL_ST_IDLE && i_start && !i_flush;
    assign o_step  = state == MUL_ST_RUN;
    assign o_ready = state == MUL_ST_DONE;

    // A multiply only leaves the stage with its product complete
    a_accept_ready: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_start && i_accept |-> o_ready);

    // Every run starts from a fresh load, so a flushed multiply restarts
    a_run_entry: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_step && !$past(o_step) |-> $past(o_load));

endmodule

`default_nettype wire

// File: hdl/mul_step_counter.sv
// Step counter for one multiply, last is only flagged while stepping
`timescale 1ns/100ps
`default_nettype none

module mul_step_counter (
    input  logic g_clk,
    input  logic g_resetn,
    input  logic i_load,                // Start of a multiply
    input  logic i_step,
    output logic o_last                 // Step MUL_STEPS-1 under way
);
    import exec_pkg::*;

    logic [MUL_CNT_W-1:0] cnt;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cnt <= '0;
        end else if (i_load) begin
            cnt <= '0;
        end else if (i_step) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_last = i_step && cnt == MUL_CNT_W'(MUL_STEPS - 1);

    a_cnt_bound: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cnt <= MUL_CNT_W'(MUL_STEPS));

endmodule

`default_nettype wire

// File: hdl/mul_datapath.sv
// Shift-add unsigned multiplier, one multiplier bit per step
// Product is only meaningful after MUL_STEPS steps following a load
`timescale 1ns/100ps
`default_nettype none

module mul_datapath (
    input  logic                          g_clk,
    input  logic                          g_resetn,
    input  logic                          i_load,    // Capture operands
    input  logic                          i_step,    // One shift-add
    input  exec_pkg::xword_t              i_rs1,     // Multiplicand
    input  exec_pkg::xword_t              i_rs2,     // Multiplier
    output logic [2*exec_pkg::XLEN-1:0]   o_product
);
    import exec_pkg::*;

    logic [2*XLEN-1:0] mcand;           // Shifted left each step
    xword_t            mplier;          // Shifted right, bit 0 is current

    always_ff @(posedge g_clk) begin
        if (i_load) begin
            mcand  <= {{XLEN{1'b0}}, i_rs1};
            mplier <= i_rs2;
        end else if (i_step) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_product <= '0;
        end else if (i_load) begin
            o_product <= '0;
        end else if (i_step && mplier[0]) begin
            o_product <= o_product + mcand;     // Partial product in
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_pipe_reg.sv
// Single-entry stage-3 output register without a skid buffer
// Holds its word while stage 3 is busy and passes busy upstream
`timescale 1ns/100ps
`default_nettype none

module exec_pipe_reg (
    input  logic                         g_clk,
    input  logic                         g_resetn,
    input  logic                         i_valid,   // Accepted from stage 2
    input  logic                         i_flush,
    input  logic                         i_busy,    // Stage 3 busy
    input  logic [exec_pkg::REG_W-1:0]   i_rd,
    input  exec_pkg::xword_t             i_opr_a,
    input  exec_pkg::xword_t             i_opr_b,
    input  exec_pkg::uop_t               i_uop,
    input  exec_pkg::fu_t                i_fu,
    output logic                         o_busy,    // Full and blocked
    output logic                         o_valid,
    output logic [exec_pkg::REG_W-1:0]   o_rd,
    output exec_pkg::xword_t             o_opr_a,
    output exec_pkg::xword_t             o_opr_b,
    output exec_pkg::uop_t               o_uop,
    output exec_pkg::fu_t                o_fu
);
    logic load;                         // Register may take a new word

    assign load   = !o_valid || !i_busy;
    assign o_busy = o_valid && i_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (load && i_valid) begin
            o_rd    <= i_rd;
            o_opr_a <= i_opr_a;
            o_opr_b <= i_opr_b;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
        end
    end

    // A word arriving while the register is blocked would be lost
    a_no_overrun: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_valid |-> !o_busy);

endmodule

`default_nettype wire

// File: hdl/exec_stage.sv
// Execute stage, ALU, branch compare, load/store address and multiply
// Stage 2 must hold its inputs while o_s2_busy is high
// A multiply holds busy for MUL_STEPS+1 cycles before it can be accepted
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        i_s2_valid,
    input  logic                        i_flush,
    input  logic                        i_s3_busy,
    input  logic [exec_pkg::REG_W-1:0]  i_s2_rd,
    input  exec_pkg::xword_t            i_s2_opr_a,
    input  exec_pkg::xword_t            i_s2_opr_b,
    input  exec_pkg::xword_t            i_s2_opr_c,
    input  exec_pkg::uop_t              i_s2_uop,
    input  exec_pkg::fu_t               i_s2_fu,
    output logic                        o_s2_busy,
    output logic [exec_pkg::REG_W-1:0]  o_fwd_rd,
    output exec_pkg::xword_t            o_fwd_wdata,
    output logic                        o_fwd_load,
    output logic [exec_pkg::REG_W-1:0]  o_s3_rd,
    output exec_pkg::xword_t            o_s3_opr_a,
    output exec_pkg::xword_t            o_s3_opr_b,
    output exec_pkg::uop_t              o_s3_uop,
    output exec_pkg::fu_t               o_s3_fu,
    output logic                        o_s3_valid
);
    import exec_pkg::*;

    logic              pipe_progress;   // Instruction accepted this edge
    logic              p_busy;          // Output register blocked
    logic              mul_req;
    logic              mul_load;
    logic              mul_step;
    logic              mul_last;
    logic              mul_ready;
    logic [2*XLEN-1:0] mul_product;
    xword_t            alu_result;
    xword_t            alu_sum;
    logic              alu_lt;
    logic              alu_eq;
    xword_t            n_opr_a;         // Next stage-3 operands
    xword_t            n_opr_b;
    uop_t              n_uop;

    // ------------------------------
    // Stall and progress
    assign mul_req       = i_s2_valid && i_s2_fu[P_FU_MUL];
    assign o_s2_busy     = p_busy || (mul_req && !mul_ready);
    assign pipe_progress = i_s2_valid && !o_s2_busy;
    assign o_fwd_rd      = i_s2_rd;

    exec_alu u_alu (
        .i_fu_alu (i_s2_fu[P_FU_ALU]),
        .i_fu_cfu (i_s2_fu[P_FU_CFU]),
        .i_uop    (i_s2_uop),
        .i_lhs    (i_s2_opr_a),
        .i_rhs    (i_s2_opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    // ------------------------------
    // Multiplier
    mul_ctrl_fsm u_mul_fsm (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_start  (mul_req),
        .i_accept (pipe_progress),
        .i_flush  (i_flush),
        .i_last   (mul_last),
        .o_load   (mul_load),
        .o_step   (mul_step),
        .o_ready  (mul_ready)
    );

    mul_step_counter u_mul_cnt (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_load   (mul_load),
        .i_step   (mul_step),
        .o_last   (mul_last)
    );

    mul_datapath u_mul_dp (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .i_load    (mul_load),
        .i_step    (mul_step),
        .i_rs1     (i_s2_opr_a),
        .i_rs2     (i_s2_opr_b),
        .o_product (mul_product)
    );

    exec_result_sel u_sel (
        .i_fu         (i_s2_fu),
        .i_uop        (i_s2_uop),
        .i_opr_c      (i_s2_opr_c),
        .i_alu_result (alu_result),
        .i_alu_sum    (alu_sum),
        .i_lt         (alu_lt),
        .i_eq         (alu_eq),
        .i_product    (mul_product),
        .o_opr_a      (n_opr_a),
        .o_opr_b      (n_opr_b),
        .o_uop        (n_uop),
        .o_fwd_wdata  (o_fwd_wdata),
        .o_fwd_load   (o_fwd_load)
    );

    exec_pipe_reg u_pipe (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_valid  (pipe_progress),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .i_rd     (i_s2_rd),
        .i_opr_a  (n_opr_a),
        .i_opr_b  (n_opr_b),
        .i_uop    (n_uop),
        .i_fu     (i_s2_fu),
        .o_busy   (p_busy),
        .o_valid  (o_s3_valid),
        .o_rd     (o_s3_rd),
        .o_opr_a  (o_s3_opr_a),
        .o_opr_b  (o_s3_opr_b),
        .o_uop    (o_s3_uop),
        .o_fu     (o_s3_fu)
    );

endmodule

`default_nettype wire

// File: tb/tb_exec_stage.sv
// Self-checking testbench for the execute stage with LFSR stimulus from seed 52
// Expected stage-3 words come from the ISA rules and wait in a queue until consumed
// Stage 2 drops its instruction on a flush, as the real pipeline does
`timescale 1ns/100ps
`default_nettype none

module tb_exec_stage;
    import exec_pkg::*;

    localparam int N_OPS       = 200;
    localparam int TIMEOUT_CYC = N_OPS * (MUL_STEPS + 4) + 8 + 100;
    localparam int ITEM_W      = REG_W + 2*XLEN + 5 + 4;    // rd, a, b, uop, fu

    localparam logic [4:0] ALU_OPS [10] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                                            ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
    localparam logic [4:0] CFU_OPS [8]  = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU,
                                            CFU_BGEU, CFU_JALI, CFU_JALR};

    logic              g_clk;
    logic              g_resetn;
    logic              i_s2_valid;
    logic              i_flush;
    logic              i_s3_busy;
    logic [REG_W-1:0]  i_s2_rd;
    xword_t            i_s2_opr_a;
    xword_t            i_s2_opr_b;
    xword_t            i_s2_opr_c;
    uop_t              i_s2_uop;
    fu_t               i_s2_fu;
    logic              o_s2_busy;
    logic [REG_W-1:0]  o_fwd_rd;
    xword_t            o_fwd_wdata;
    logic              o_fwd_load;
    logic [REG_W-1:0]  o_s3_rd;
    xword_t            o_s3_opr_a;
    xword_t            o_s3_opr_b;
    uop_t              o_s3_uop;
    fu_t               o_s3_fu;
    logic              o_s3_valid;

    logic [31:0]       lfsr;                    // Galois LFSR state
    logic [ITEM_W-1:0] exp_q[$];                // Accepted, not yet consumed
    logic [ITEM_W-1:0] got_item;                // Stage-3 word as seen
    int                mul_wait   = 0;          // Edges the multiply has waited
    int                n_mismatch = 0;
    int                n_other    = 0;
    int                n_checked  = 0;
    int                n_started  = 0;
    int                cycles     = 0;
    logic              stim_done;

    exec_stage u_dut (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_s2_valid  (i_s2_valid),
        .i_flush     (i_flush),
        .i_s3_busy   (i_s3_busy),
        .i_s2_rd     (i_s2_rd),
        .i_s2_opr_a  (i_s2_opr_a),
        .i_s2_opr_b  (i_s2_opr_b),
        .i_s2_opr_c  (i_s2_opr_c),
        .i_s2_uop    (i_s2_uop),
        .i_s2_fu     (i_s2_fu),
        .o_s2_busy   (o_s2_busy),
        .o_fwd_rd    (o_fwd_rd),
        .o_fwd_wdata (o_fwd_wdata),
        .o_fwd_load  (o_fwd_load),
        .o_s3_rd     (o_s3_rd),
        .o_s3_opr_a  (o_s3_opr_a),
        .o_s3_opr_b  (o_s3_opr_b),
        .o_s3_uop    (o_s3_uop),
        .o_s3_fu     (o_s3_fu),
        .o_s3_valid  (o_s3_valid)
    );

    assign got_item = {o_s3_rd, o_s3_opr_a, o_s3_opr_b, o_s3_uop, o_s3_fu};

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;             // 40 ns period
    end

    // ------------------------------
    // Random source
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);             // One step per bit
        end
        return v;
    endfunction

    function automatic string item_text(input logic [ITEM_W-1:0] w);
        return $sformatf("rd=%0d a=%h b=%h uop=%b fu=%b", w[ITEM_W-1 -: REG_W],
                         w[9+XLEN +: XLEN], w[9 +: XLEN], w[4 +: 5], w[0 +: 4]);
    endfunction

    // ------------------------------
    // Reference model from the ISA rules
    task automatic predict_result(
        input  fu_t        fu,
        input  uop_t       uop,
        input  xword_t     a,
        input  xword_t     b,
        input  xword_t     c,
        output xword_t     ea,
        output xword_t     eb,
        output logic [4:0] euop
    );
        logic        taken;
        logic [63:0] prod;
        ea    = '0;
        eb    = '0;
        euop  = uop.code;                       // Passes through unless a branch
        taken = 1'b0;
        prod  = 64'(a) * 64'(b);
        if (fu[P_FU_ALU]) begin
            case (uop.code)
                ALU_ADD:  ea = a + b;
                ALU_SUB:  ea = a - b;
                ALU_XOR:  ea = a ^ b;
                ALU_OR:   ea = a | b;
                ALU_AND:  ea = a & b;
                ALU_SLL:  ea = a << b[4:0];
                ALU_SRL:  ea = a >> b[4:0];
                ALU_SRA:  ea = xword_t'($signed(a) >>> b[4:0]);
                ALU_SLT:  ea = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                ALU_SLTU: ea = {{(XLEN-1){1'b0}}, a < b};
                default:  ea = '0;
            endcase
        end else if (fu[P_FU_MUL]) begin
            {eb, ea} = prod;                    // High word in b
        end else if (fu[P_FU_LSU]) begin
            ea = a + b;                         // Address
            eb = c;                             // Store data
        end else if (fu[P_FU_CFU]) begin
            case (uop.code)
                CFU_BEQ:  taken = (a == b);
                CFU_BNE:  taken = (a != b);
                CFU_BLT:  taken = $signed(a) < $signed(b);
                CFU_BGE:  taken = $signed(a) >= $signed(b);
                CFU_BLTU: taken = a < b;
                CFU_BGEU: taken = a >= b;
                default:  taken = 1'b0;
            endcase
            ea = (uop.code == CFU_JALR) ? ((a + b) & ~32'd1) : (c & ~32'd1);
            if (uop.code != CFU_JALI && uop.code != CFU_JALR) begin
                euop = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
            end
        end
    endtask

    task automatic drive_instruction();
        logic [2:0] pick;
        int         idx;
        xword_t     a;
        pick = 3'(take_bits(3));
        a    = take_bits(32);
        i_s2_valid <= 1'b1;
        i_s2_rd    <= REG_W'(take_bits(REG_W));
        i_s2_opr_a <= a;
        i_s2_opr_b <= (take_bits(2) == 32'd0) ? a : take_bits(32);  // Hit equal compares
        i_s2_opr_c <= take_bits(32);
        case (pick)
            3'd0, 3'd1, 3'd2: begin
                idx = int'(take_bits(4) % 10);
                i_s2_fu       <= fu_t'(32'd1 << P_FU_ALU);
                i_s2_uop.code <= ALU_OPS[idx];
            end
            3'd3: begin
                i_s2_fu       <= fu_t'(32'd1 << P_FU_MUL);
                i_s2_uop.code <= take_bits(1) == 32'd1 ? MUL_MULHU : MUL_MUL;
            end
            3'd4, 3'd5: begin
                i_s2_fu       <= fu_t'(32'd1 << P_FU_LSU);
                i_s2_uop.code <= 5'(take_bits(4));  // Bit 3 picks load or store
            end
            default: begin
                idx = int'(take_bits(3));
                i_s2_fu       <= fu_t'(32'd1 << P_FU_CFU);
                i_s2_uop.code <= CFU_OPS[idx];
            end
        endcase
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatches, %0d other failures, %0d items checked",
                 n_mismatch, n_other, n_checked);
    endtask

    // ------------------------------
    // Scoreboard
    always @(posedge g_clk) begin : scoreboard
        xword_t            ea;
        xword_t            eb;
        logic [4:0]        euop;
        xword_t            efwd;
        logic [ITEM_W-1:0] exp_item;
        if (!g_resetn) begin
            mul_wait <= 0;
        end else if (i_flush) begin
            exp_q.delete();                     // Flushed word never reaches stage 3
            mul_wait <= 0;
        end else begin
            if (o_s3_valid && !i_s3_busy) begin
                if (exp_q.size() == 0) begin
                    n_other++;
                    $display("Stage 3 got an item at %0t that was never accepted", $time);
                end else begin
                    exp_item = exp_q.pop_front();
                    n_checked++;
                    a_s3_word: assert (got_item == exp_item) else begin
                        n_mismatch++;
                        $display("Mismatch at %0t: stage 3 got %s, expected %s", $time,
                                 item_text(got_item), item_text(exp_item));
                    end
                end
            end
            if (i_s2_valid && !o_s2_busy) begin
                predict_result(i_s2_fu, i_s2_uop, i_s2_opr_a, i_s2_opr_b, i_s2_opr_c,
                               ea, eb, euop);
                efwd = i_s2_fu[P_FU_ALU] ? ea :
                       !i_s2_fu[P_FU_MUL] ? '0 :
                       (i_s2_uop.code == MUL_MULHU) ? eb : ea;
                exp_q.push_back({i_s2_rd, ea, eb, euop, i_s2_fu});
                a_fwd: assert (o_fwd_rd == i_s2_rd && o_fwd_wdata == efwd &&
                               o_fwd_load == (i_s2_fu[P_FU_LSU] &&
                                              i_s2_uop.code[LSU_LOAD_BIT])) else begin
                    n_mismatch++;
                    $display("Mismatch at %0t: forward rd=%0d wdata=%h load=%b, %s",
                             $time, o_fwd_rd, o_fwd_wdata, o_fwd_load,
                             $sformatf("expected rd=%0d wdata=%h", i_s2_rd, efwd));
                end
                mul_wait <= 0;
            end else if (i_s2_valid && i_s2_fu[P_FU_MUL]) begin
                mul_wait <= mul_wait + 1;
            end
        end
    end

    // ------------------------------
    // Handshake properties
    a_s3_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s3_valid && i_s3_busy && !i_flush |=> o_s3_valid && $stable(got_item))
        else begin
            n_mismatch++;
            $display("Mismatch at %0t: stage-3 word moved while stage 3 was busy", $time);
        end

    a_flush_drop: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_flush |=> !o_s3_valid)
        else begin
            n_other++;
            $display("Stage-3 valid still high after a flush at %0t", $time);
        end

    // Busy covers IDLE and all of RUN, then only back-pressure may hold it
    a_mul_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid && i_s2_fu[P_FU_MUL] && mul_wait <= MUL_STEPS |-> o_s2_busy)
        else begin
            n_other++;
            $display("Busy dropped at %0t before the product was ready", $time);
        end

    a_mul_done: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid && i_s2_fu[P_FU_MUL] && mul_wait > MUL_STEPS |->
            o_s2_busy == (o_s3_valid && i_s3_busy))
        else begin
            n_other++;
            $display("Busy at %0t does not follow stage 3 after the multiply ended", $time);
        end

    // ------------------------------
    // Stimulus
    initial begin : stimulus
        lfsr       = 32'd52;
        g_resetn   = 1'b0;
        i_s2_valid = 1'b0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop   = '0;
        i_s2_fu    = '0;
        stim_done  = 1'b0;
        repeat (8) @(posedge g_clk);
        g_resetn <= 1'b1;
        while (!stim_done) begin
            @(posedge g_clk);
            i_s3_busy <= (take_bits(2) == 32'd0);       // Busy one cycle in four
            if (i_flush) begin
                i_flush <= 1'b0;
            end else if (take_bits(6) == 32'd0) begin
                i_flush    <= 1'b1;                     // Stage 2 is flushed too
                i_s2_valid <= 1'b0;
            end else if (!(i_s2_valid && o_s2_busy)) begin
                if (n_started == N_OPS) begin
                    i_s2_valid <= 1'b0;
                    stim_done = 1'b1;
                end else if (take_bits(2) == 32'd0) begin
                    i_s2_valid <= 1'b0;                 // Bubble
                end else begin
                    drive_instruction();
                    n_started++;
                end
            end
        end
        @(posedge g_clk);
        i_s3_busy <= 1'b0;
        @(posedge g_clk);
        while (o_s3_valid) begin
            @(posedge g_clk);
        end
        a_drained: assert (exp_q.size() == 0) else begin
            n_other++;
            $display("%0d accepted items never reached stage 3", exp_q.size());
        end
        a_any_checked: assert (n_checked > 0) else begin
            n_other++;
            $display("No item reached stage 3 during the run");
        end
        print_counts();
        if (n_mismatch == 0 && n_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycles < TIMEOUT_CYC) begin
            @(posedge g_clk);
            cycles++;
        end
        n_other++;
        $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
        print_counts();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_result_sel.sv
hdl/mul_ctrl_fsm.sv
hdl/mul_step_counter.sv
hdl/mul_datapath.sv
hdl/exec_pipe_reg.sv
hdl/exec_stage.sv
tb/tb_exec_stage.sv

// File: Makefile
TOP := tb_exec_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module exec_stage

sim:
	verilator --binary --assert --timing -j 0 -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
